// File: design/periph_bus_pkg.sv
// ####################
// host bus types, always ready with no wait states
// a request is live only while en is high
// ####################

`default_nettype none

package periph_bus_pkg;

   typedef logic [63:0] bus_data_t;   // read and write data word
   typedef logic [17:0] bus_addr_t;   // byte address
   typedef logic [7:0]  bus_be_t;     // byte-write enables
   typedef logic [2:0]  bus_region_t; // top address bits pick the block

   // region field in the address
   localparam int REGION_HI = 17;
   localparam int REGION_LO = 15;

   localparam bus_region_t REGION_UART = 3'd6;

   // write when en and any we bit, read when en and no we bit
   typedef struct packed {
      logic      en;
      bus_be_t   we;
      bus_addr_t addr;
      bus_data_t wdata;
   } bus_req_t;

endpackage

`default_nettype wire

// File: design/uart_pkg.sv
// ####################
// uart types and register map
// baud divider below 2 is not supported
// ####################

`default_nettype none

package uart_pkg;

   typedef logic [7:0]  uart_byte_t;
   typedef logic [15:0] baud_div_t;   // msoc_clk cycles per bit
   typedef logic [15:0] fifo_level_t;

   // one received frame as stored in the rx fifo
   typedef struct packed {
      logic       err;  // stop bit was 0
      uart_byte_t data;
   } uart_entry_t;

   // address bits inside the uart region
   localparam int ADDR_UART_EN  = 14;  // 1 selects the uart half
   localparam int ADDR_READ_LVL = 13;  // reads: 1 gives fill levels
   localparam int ADDR_OP_HI    = 13;
   localparam int ADDR_OP_LO    = 12;

   typedef enum logic [1:0] {
      OP_PUSH_TX  = 2'd0,
      OP_POP_RX   = 2'd1,
      OP_SET_BAUD = 2'd2,
      OP_NONE     = 2'd3
   } uart_op_t;

   // status word bits above the rx head byte
   localparam int ST_ERR      = 8;
   localparam int ST_RX_EMPTY = 9;
   localparam int ST_TX_FULL  = 10;
   localparam int ST_RX_FULL  = 11;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

`default_nettype wire

// File: design/uart_fifo.sv
// ####################
// FIFO_DEPTH must be a power of two
// push while full is dropped, no pass-through
// ####################

`timescale 1ns/1ps
`default_nettype none

module uart_fifo
   import uart_pkg::*;
#(
   parameter int WIDTH      = 8,
   parameter int FIFO_DEPTH = 16
) (
   input  logic             msoc_clk,
   input  logic             rstn,
   input  logic [WIDTH-1:0] in_data_i,
   input  logic             in_valid_i,
   output logic             in_ready_o,
   output logic [WIDTH-1:0] out_data_o,
   output logic             out_valid_o,
   input  logic             out_ready_i,
   output fifo_level_t      level_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   logic [WIDTH-1:0] mem_q [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   fifo_level_t      count_q;
   logic             wr_en;
   logic             rd_en;

   assign in_ready_o  = (count_q != fifo_level_t'(FIFO_DEPTH)); // not full
   assign out_valid_o = (count_q != '0);                        // not empty
   assign wr_en       = in_valid_i & in_ready_o;
   assign rd_en       = out_valid_o & out_ready_i;
   assign out_data_o  = mem_q[rd_ptr_q];                        // head of queue
   assign level_o     = count_q;

   always_ff @(posedge msoc_clk)
   begin
      if (wr_en)
         mem_q[wr_ptr_q] <= in_data_i;
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
         if (rd_en)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (wr_en && !rd_en)
            count_q <= count_q + 1'b1;
         else if (rd_en && !wr_en)
            count_q <= count_q - 1'b1;
      end
   end

   a_no_overflow: assert property (@(posedge msoc_clk) disable iff (!rstn)
      count_q <= fifo_level_t'(FIFO_DEPTH))
      else $error("fifo write past full");

   // pointer distance must agree with the count, a read when empty breaks it
   a_no_underflow: assert property (@(posedge msoc_clk) disable iff (!rstn)
      PTR_W'(wr_ptr_q - rd_ptr_q) == PTR_W'(count_q))
      else $error("fifo read while empty");

endmodule

`default_nettype wire

// File: design/uart_tx.sv
// ####################
// 8N1 transmitter, baud_div latched per frame
// ####################

`timescale 1ns/1ps
`default_nettype none

module uart_tx
   import uart_pkg::*;
(
   input  logic       msoc_clk,
   input  logic       rstn,
   input  baud_div_t  baud_div_i,
   input  uart_byte_t data_i,
   input  logic       valid_i,
   output logic       ready_o,
   output logic       tx_o
);

   tx_state_e  state_q;
   baud_div_t  cnt_q;
   baud_div_t  div_q;
   uart_byte_t shift_q;
   logic [2:0] idx_q;
   logic       tx_q;
   logic       bit_end;

   assign ready_o = (state_q == TX_IDLE);
   assign tx_o    = tx_q;
   assign bit_end = (cnt_q == div_q - 1'b1); // last cycle of a bit period

   always_ff @(posedge msoc_clk)
   begin
      if (ready_o && valid_i)
         shift_q <= data_i;
      else if (state_q == TX_DATA && bit_end)
         shift_q <= shift_q >> 1; // lsb first
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state_q <= TX_IDLE;
         cnt_q   <= '0;
         div_q   <= '0;
         idx_q   <= '0;
         tx_q    <= 1'b1; // line idles high
      end
      else
      begin
         cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
         case (state_q)
            TX_IDLE:
            begin
               cnt_q <= '0;
               if (valid_i)
               begin
                  div_q   <= baud_div_i;
                  tx_q    <= 1'b0; // start bit
                  state_q <= TX_START;
               end
            end
            TX_START:
               if (bit_end)
               begin
                  tx_q    <= shift_q[0];
                  idx_q   <= '0;
                  state_q <= TX_DATA;
               end
            TX_DATA:
               if (bit_end)
               begin
                  idx_q <= idx_q + 1'b1;
                  if (idx_q == 3'd7)
                  begin
                     tx_q    <= 1'b1; // stop bit
                     state_q <= TX_STOP;
                  end
                  else
                     tx_q <= shift_q[1];
               end
            default:
               if (bit_end)
                  state_q <= TX_IDLE;
         endcase
      end
   end

   a_tx_state: assert property (@(posedge msoc_clk) disable iff (!rstn)
      ready_o |-> tx_o)
      else $error("uart_tx line low while idle");

endmodule

`default_nettype wire

// File: design/uart_rx.sv
// ####################
// 8N1 receiver behind a 3-flop majority filter
// filter adds 3 cycles, bits sampled at mid-bit
// ####################

`timescale 1ns/1ps
`default_nettype none

module uart_rx
   import uart_pkg::*;
(
   input  logic        msoc_clk,
   input  logic        rstn,
   input  baud_div_t   baud_div_i,
   input  logic        rx_i,
   output uart_entry_t entry_o,
   output logic        valid_o
);

   logic [2:0]  sync_q;
   logic        maj;
   logic        maj_q;
   rx_state_e   state_q;
   baud_div_t   cnt_q;
   baud_div_t   div_q;
   logic [2:0]  idx_q;
   uart_byte_t  shift_q;
   uart_entry_t entry_q;
   logic        valid_q;
   logic        bit_end;
   logic        half_end;

   // two of three samples win
   assign maj      = (sync_q[0] & sync_q[1]) | (sync_q[0] & sync_q[2]) |
                     (sync_q[1] & sync_q[2]);
   assign bit_end  = (cnt_q == div_q - 1'b1);
   assign half_end = (cnt_q == (div_q >> 1) - 1'b1); // middle of start bit
   assign entry_o  = entry_q;
   assign valid_o  = valid_q;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         sync_q <= 3'b111;
         maj_q  <= 1'b1;
      end
      else
      begin
         sync_q <= {sync_q[1:0], rx_i};
         maj_q  <= maj;
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (state_q == RX_DATA && bit_end)
         shift_q <= {maj_q, shift_q[7:1]}; // lsb arrives first
      if (state_q == RX_STOP && bit_end)
         entry_q <= '{err: ~maj_q, data: shift_q};
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state_q <= RX_IDLE;
         cnt_q   <= '0;
         div_q   <= '0;
         idx_q   <= '0;
         valid_q <= 1'b0;
      end
      else
      begin
         valid_q <= 1'b0;
         cnt_q   <= cnt_q + 1'b1;
         case (state_q)
            RX_IDLE:
            begin
               cnt_q <= '0;
               if (!maj_q) // falling edge of start bit
               begin
                  div_q   <= baud_div_i;
                  state_q <= RX_START;
               end
            end
            RX_START:
               if (half_end)
               begin
                  cnt_q   <= '0;
                  idx_q   <= '0;
                  state_q <= maj_q ? RX_IDLE : RX_DATA; // glitch goes back
               end
            RX_DATA:
               if (bit_end)
               begin
                  cnt_q <= '0;
                  idx_q <= idx_q + 1'b1;
                  if (idx_q == 3'd7)
                     state_q <= RX_STOP;
               end
            default:
               if (bit_end)
               begin
                  valid_q <= 1'b1;
                  state_q <= RX_IDLE;
               end
         endcase
      end
   end

   a_rx_state: assert property (@(posedge msoc_clk) disable iff (!rstn)
      valid_q |=> !valid_q)
      else $error("uart_rx valid longer than one cycle");

endmodule

`default_nettype wire

// File: design/uart_regs.sv
// ####################
// uart register block, acts on sel with addr bit 14 set
// tx push to a full fifo is dropped
// ####################

`timescale 1ns/1ps
`default_nettype none

module uart_regs
   import periph_bus_pkg::*;
   import uart_pkg::*;
#(
   parameter int BAUD_DIV_RESET = 54,
   parameter int FIFO_DEPTH     = 16
) (
   input  logic      msoc_clk,
   input  logic      rstn,
   input  bus_req_t  bus_req_i,
   input  logic      sel_i,
   output bus_data_t rdata_o,
   input  logic      uart_rx_i,
   output logic      uart_tx_o,
   output logic      irq_o
);

   logic        acc;
   logic        wr;
   uart_op_t    op;
   baud_div_t   baud_div_q;
   logic        irq_q;
   logic        tx_push;
   logic        tx_full;
   logic        tx_full_n;
   uart_byte_t  tx_byte;
   logic        tx_valid;
   logic        tx_ready;
   fifo_level_t tx_level;
   uart_entry_t rx_entry;
   logic        rx_valid;
   logic        rx_in_ready;
   uart_entry_t rx_head;
   logic        rx_out_valid;
   logic        rx_pop;
   fifo_level_t rx_level;
   bus_data_t   status_word;

   assign acc     = sel_i & bus_req_i.addr[ADDR_UART_EN];
   assign wr      = acc & bus_req_i.en & (|bus_req_i.we);
   assign op      = uart_op_t'(bus_req_i.addr[ADDR_OP_HI:ADDR_OP_LO]);
   assign tx_push = wr & (op == OP_PUSH_TX);
   assign rx_pop  = wr & (op == OP_POP_RX) & rx_out_valid; // empty pop ignored
   assign irq_o   = irq_q;
   assign tx_full = ~tx_full_n;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         baud_div_q <= baud_div_t'(BAUD_DIV_RESET);
         irq_q      <= 1'b0;
      end
      else
      begin
         irq_q <= rx_out_valid; // data waiting
         if (wr && op == OP_SET_BAUD)
            baud_div_q <= bus_req_i.wdata[15:0];
      end
   end

   always_comb
   begin
      status_word              = '0;
      status_word[7:0]         = rx_head.data;
      status_word[ST_ERR]      = rx_head.err;
      status_word[ST_RX_EMPTY] = ~rx_out_valid;
      status_word[ST_TX_FULL]  = tx_full;
      status_word[ST_RX_FULL]  = ~rx_in_ready;
   end

   assign rdata_o = !acc ? '0 :
                    bus_req_i.addr[ADDR_READ_LVL] ? {32'b0, tx_level, rx_level} :
                    status_word;

   uart_fifo #(.WIDTH(8), .FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .in_data_i   (bus_req_i.wdata[7:0]),
      .in_valid_i  (tx_push),
      .in_ready_o  (tx_full_n),
      .out_data_o  (tx_byte),
      .out_valid_o (tx_valid),
      .out_ready_i (tx_ready),
      .level_o     (tx_level)
   );

   uart_tx u_uart_tx (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .baud_div_i (baud_div_q),
      .data_i     (tx_byte),
      .valid_i    (tx_valid),
      .ready_o    (tx_ready),
      .tx_o       (uart_tx_o)
   );

   uart_rx u_uart_rx (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .baud_div_i (baud_div_q),
      .rx_i       (uart_rx_i),
      .entry_o    (rx_entry),
      .valid_o    (rx_valid)
   );

   uart_fifo #(.WIDTH(9), .FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .in_data_i   (rx_entry),
      .in_valid_i  (rx_valid),     // frame lost when full
      .in_ready_o  (rx_in_ready),
      .out_data_o  (rx_head),
      .out_valid_o (rx_out_valid),
      .out_ready_i (rx_pop),
      .level_o     (rx_level)
   );

   // host pop on an empty rx fifo must not move its level
   a_pop_not_empty: assert property (@(posedge msoc_clk) disable iff (!rstn)
      wr && op == OP_POP_RX && !rx_out_valid && !rx_valid |=> rx_level == $past(rx_level))
      else $error("pop issued to an empty fifo");

endmodule

`default_nettype wire

// File: design/periph_top.sv
// ####################
// peripheral top, uart in region 6 only
// read data valid one cycle after the request
// ####################

`timescale 1ns/1ps
`default_nettype none

module periph_top
   import periph_bus_pkg::*;
#(
   parameter int BAUD_DIV_RESET = 54,
   parameter int FIFO_DEPTH     = 16
) (
   input  logic      msoc_clk,
   input  logic      rstn,
   input  bus_req_t  bus_req_i,
   output bus_data_t bus_rdata_o,
   input  logic      uart_rx_i,
   output logic      uart_tx_o,
   output logic      uart_irq_o
);

   bus_region_t region;
   logic        uart_sel;
   logic        rd_req;
   bus_data_t   uart_rdata;
   bus_data_t   rdata_q;

   assign region      = bus_region_t'(bus_req_i.addr[REGION_HI:REGION_LO]);
   assign uart_sel    = (region == REGION_UART);
   assign rd_req      = bus_req_i.en & ~(|bus_req_i.we);
   assign bus_rdata_o = rdata_q;

   // other regions read back zero
   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
         rdata_q <= '0;
      else
         rdata_q <= (rd_req && uart_sel) ? uart_rdata : '0;
   end

   uart_regs #(
      .BAUD_DIV_RESET (BAUD_DIV_RESET),
      .FIFO_DEPTH     (FIFO_DEPTH)
   ) u_uart_regs (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .bus_req_i (bus_req_i),
      .sel_i     (uart_sel),
      .rdata_o   (uart_rdata),
      .uart_rx_i (uart_rx_i),
      .uart_tx_o (uart_tx_o),
      .irq_o     (uart_irq_o)
   );

endmodule

`default_nettype wire

// File: testbench/tb_periph_top.sv
// ####################
// uart tx looped back to rx, one host at a time on the bus
// rx head bits are not compared while the rx fifo is empty
// ####################

`timescale 1ns/1ps
`default_nettype none

module tb_periph_top
   import periph_bus_pkg::*;
   import uart_pkg::*;
();

   localparam int          BAUD_RESET = 54;
   localparam int          FIFO_DEPTH = 16;
   localparam int          BIG_DIV    = 400;
   localparam int          TIMEOUT_CYCLES = (40 * 10 * BIG_DIV) + 40000; // forty frames plus margin
   localparam logic [31:0] SEED       = 32'h40fb_581b;

   // uart region with bit 14 set, op field in bits 13:12
   localparam bus_addr_t A_PUSH   = {REGION_UART, 1'b1, 2'd0, 12'h000};
   localparam bus_addr_t A_POP    = {REGION_UART, 1'b1, 2'd1, 12'h000};
   localparam bus_addr_t A_BAUD   = {REGION_UART, 1'b1, 2'd2, 12'h000};
   localparam bus_addr_t A_STATUS = A_PUSH;  // read with bit 13 low
   localparam bus_addr_t A_LEVELS = A_BAUD;  // read with bit 13 high

   logic        msoc_clk;
   logic        rstn;
   bus_req_t    bus_req;
   bus_data_t   bus_rdata;
   logic        uart_tx;
   logic        uart_rx;
   logic        uart_irq;

   uart_byte_t  tx_model[$];   // bytes waiting in the tx fifo
   uart_entry_t rx_model[$];   // entries waiting in the rx fifo
   uart_byte_t  mon_q[$];      // bytes decoded from the line
   logic        eng_busy;
   int          mon_div;
   int          err_cnt;
   int          test_err_start;
   int          n_tests;
   int          n_failed;
   int          cycle_cnt;
   string       cur_test;

   assign uart_rx = uart_tx;  // serial loopback

   periph_top #(
      .BAUD_DIV_RESET (BAUD_RESET),
      .FIFO_DEPTH     (FIFO_DEPTH)
   ) u_periph_top (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .bus_req_i   (bus_req),
      .bus_rdata_o (bus_rdata),
      .uart_rx_i   (uart_rx),
      .uart_tx_o   (uart_tx),
      .uart_irq_o  (uart_irq)
   );

   initial
      msoc_clk = 1'b0;

   always #10 msoc_clk = ~msoc_clk;

   always @(posedge msoc_clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("timeout after %0d cycles, a wait never ended", cycle_cnt);
         $display("tests failed");
         $finish;
      end
   end

   task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // all bus tasks start and end 2 ns after a rising edge
   task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
      bus_req.en    = 1'b1;
      bus_req.we    = 8'hff;
      bus_req.addr  = addr;
      bus_req.wdata = data;
      @(posedge msoc_clk);
      #2;
      bus_req = '0;
   endtask

   task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
      bus_req.en    = 1'b1;
      bus_req.we    = '0;
      bus_req.addr  = addr;
      bus_req.wdata = '0;
      @(posedge msoc_clk);
      #2;
      data    = bus_rdata;  // registered one cycle after the request
      bus_req = '0;
   endtask

   task automatic next_cycle();
      @(posedge msoc_clk);
      #2;
   endtask

   task automatic set_baud(input int div);
      bus_write(A_BAUD, bus_data_t'(div));
      mon_div = div;
   endtask

   // idle engine takes the first byte, then the fifo fills, then bytes drop
   task automatic push_tx_model(input uart_byte_t b);
      if (!eng_busy)
         eng_busy = 1'b1;
      else if (tx_model.size() < FIFO_DEPTH)
         tx_model.push_back(b);
   endtask

   // a finished frame frees the engine and lands in rx unless rx is full
   task automatic retire_frame(input uart_byte_t b);
      uart_entry_t e;
      if (tx_model.size() != 0)
         void'(tx_model.pop_front());
      else
         eng_busy = 1'b0;
      e.err  = 1'b0;
      e.data = b;
      if (rx_model.size() < FIFO_DEPTH)
         rx_model.push_back(e);
   endtask

   // expected status word, or levels word when lvl is set
   function automatic bus_data_t model_read(input logic lvl);
      bus_data_t w;
      w = '0;
      if (lvl)
      begin
         w[31:16] = fifo_level_t'(tx_model.size());
         w[15:0]  = fifo_level_t'(rx_model.size());
      end
      else
      begin
         if (rx_model.size() != 0)
         begin
            w[7:0]   = rx_model[0].data;
            w[ST_ERR] = rx_model[0].err;
         end
         w[ST_RX_EMPTY] = (rx_model.size() == 0);
         w[ST_TX_FULL]  = (tx_model.size() == FIFO_DEPTH);
         w[ST_RX_FULL]  = (rx_model.size() == FIFO_DEPTH);
      end
      return w;
   endfunction

   task automatic read_and_compare(input logic lvl, input string name);
      bus_data_t got;
      bus_data_t exp;
      bus_data_t mask;
      bus_read(lvl ? A_LEVELS : A_STATUS, got);
      exp  = model_read(lvl);
      mask = '1;
      if (!lvl && rx_model.size() == 0)
         mask[8:0] = '0;  // head holds stale data when empty
      check_data(name, got & mask, exp & mask);
   endtask

   task automatic open_test(input string name);
      cur_test       = name;
      test_err_start = err_cnt;
   endtask

   task automatic close_test();
      n_tests++;
      if (err_cnt == test_err_start)
         $display("test %s: ok", cur_test);
      else
      begin
         n_failed++;
         $display("test %s: FAILED with %0d errors", cur_test, err_cnt - test_err_start);
      end
   endtask

   // decodes 8N1 frames, every cycle of a bit must hold the same level
   always
   begin : line_monitor
      logic [9:0] bits;
      logic       level;
      logic       glitch;
      int         n;
      int         i;
      int         k;
      @(negedge msoc_clk);
      if (rstn === 1'b1 && uart_tx === 1'b0)
      begin
         n      = mon_div;
         glitch = 1'b0;
         for (i = 0; i < 10; i++)
         begin
            level = uart_tx;
            for (k = 1; k < n; k++)
            begin
               @(negedge msoc_clk);
               if (uart_tx !== level)
                  glitch = 1'b1;
            end
            bits[i] = level;
            if (i < 9)
               @(negedge msoc_clk);
         end
         if (glitch || bits[0] !== 1'b0 || bits[9] !== 1'b1)
         begin
            $display("monitor saw a broken frame on uart_tx_o at %0t", $time);
            err_cnt++;
         end
         mon_q.push_back(bits[8:1]);
         retire_frame(bits[8:1]);
      end
   end

   initial
   begin
      int         i;
      uart_byte_t b;
      uart_byte_t sent[$];
      bus_data_t  word;
      bus_req   = '0;
      rstn      = 1'b0;
      eng_busy  = 1'b0;
      mon_div   = BAUD_RESET;
      err_cnt   = 0;
      n_tests   = 0;
      n_failed  = 0;
      cycle_cnt = 0;
      void'($urandom(SEED));
      repeat (8) @(posedge msoc_clk);
      #2;
      rstn = 1'b1;
      next_cycle();

      open_test("reset state");
      check_bit("uart_irq_o", uart_irq, 1'b0);
      check_bit("uart_tx_o", uart_tx, 1'b1);
      read_and_compare(1'b0, "status");
      read_and_compare(1'b1, "levels");
      close_test();

      open_test("tx frames at divider 16");
      set_baud(16);
      for (i = 0; i < 3; i++)
      begin
         b = uart_byte_t'($urandom);
         sent.push_back(b);
         push_tx_model(b);
         bus_write(A_PUSH, bus_data_t'(b));
      end
      while (mon_q.size() < 3)
         next_cycle();
      for (i = 0; i < 3; i++)
         check_byte("decoded byte", mon_q[i], sent[i]);
      mon_q.delete();
      close_test();

      open_test("loopback into rx fifo");
      while (uart_irq !== 1'b1)
         next_cycle();
      bus_read(A_LEVELS, word);
      while (word[15:0] != fifo_level_t'(rx_model.size()))
         bus_read(A_LEVELS, word);  // last frame still in the receiver
      while (rx_model.size() != 0)
      begin
         read_and_compare(1'b0, "status head");
         check_bit("uart_irq_o", uart_irq, 1'b1);
         bus_write(A_POP, '0);
         void'(rx_model.pop_front());
      end
      read_and_compare(1'b0, "status after last pop");
      check_bit("uart_irq_o", uart_irq, 1'b0);
      read_and_compare(1'b1, "levels");
      close_test();

      open_test("other regions and bit 14 low");
      bus_read(18'h0_4000, word);
      check_data("bus_rdata_o region 0", word, '0);
      bus_read(18'h2_c000, word);
      check_data("bus_rdata_o region 5", word, '0);
      bus_read(18'h3_0000, word);
      check_data("bus_rdata_o uart bit 14 low", word, '0);
      bus_read(18'h3_2000, word);
      check_data("bus_rdata_o uart levels bit 14 low", word, '0);
      bus_write(18'h2_c000, 64'ha5);    // push in region 5
      bus_write(18'h3_0000, 64'h5a);    // push with bit 14 low
      bus_write(18'h3_2000, 64'd3);     // baud with bit 14 low
      bus_write(18'h3_1000, '0);        // pop with bit 14 low
      read_and_compare(1'b0, "status");
      read_and_compare(1'b1, "levels");
      repeat (4) next_cycle();
      check_bit("uart_tx_o", uart_tx, 1'b1);
      if (mon_q.size() != 0)
      begin
         $display("a stray write started a frame on uart_tx_o");
         err_cnt++;
      end
      close_test();

      open_test("tx fifo overflow");
      set_baud(BIG_DIV);
      for (i = 0; i < FIFO_DEPTH + 2; i++)
      begin
         b = uart_byte_t'($urandom);
         push_tx_model(b);
         bus_write(A_PUSH, bus_data_t'(b));
      end
      read_and_compare(1'b0, "status tx full");
      read_and_compare(1'b1, "levels");
      close_test();

      $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, err_cnt);
      if (err_cnt == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
design/periph_bus_pkg.sv
design/uart_pkg.sv
design/uart_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/periph_top.sv
testbench/tb_periph_top.sv

// File: Bender.yml
package:
  name: periph_uart

sources:
  - design/periph_bus_pkg.sv
  - design/uart_pkg.sv
  - design/uart_fifo.sv
  - design/uart_tx.sv
  - design/uart_rx.sv
  - design/uart_regs.sv
  - design/periph_top.sv
  - target: test
    files:
      - testbench/tb_periph_top.sv
